//--- vlog.f
verilog/mem_pkg.sv
verilog/mem_tag_table.sv
verilog/mem_store.sv
verilog/mem.sv
verilog/mem_issue_buffer.sv
verilog/mem_system.sv
bench/mem_system_checker.sv
bench/mem_system_tb.sv

//--- Bender.yml
package:
  name: mem_system

sources:
  # design, package first
  - files:
      - verilog/mem_pkg.sv
      - verilog/mem_tag_table.sv
      - verilog/mem_store.sv
      - verilog/mem.sv
      - verilog/mem_issue_buffer.sv
      - verilog/mem_system.sv

  # simulation only
  - target: test
    files:
      - bench/mem_system_checker.sv
      - bench/mem_system_tb.sv

//--- bench/mem_system_tb.sv
//////////////////////////////////////////////////////////////////////
// mem_system_tb
// table driven test of the issue buffer and tagged memory, with a
// shadow memory and per-tag expected load data
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_system_tb;

	typedef struct {
		mem_pkg::bus_cmd_t  op;
		mem_pkg::mem_addr_t addr;
		mem_pkg::mem_data_t data;       // store data only
		logic               exp_fault;  // address should be refused
	} stim_t;

	localparam int LAT            = int'(mem_pkg::MEM_LATENCY_IN_CYCLES);
	localparam int NUM_STIM       = 56;
	localparam int TIMEOUT_CYCLES = NUM_STIM * (LAT + mem_pkg::NUM_MEM_TAGS + 4) + 100;

	logic              clk;
	logic              rst_n;
	mem_pkg::mem_req_t proc_req;
	logic              proc_busy;
	mem_pkg::mem_tag_t proc_grant_tag;
	mem_pkg::mem_rsp_t proc_rsp;

	stim_t              stim [NUM_STIM];
	mem_pkg::mem_data_t shadow [mem_pkg::MEM_64BIT_LINES];   // reference contents
	mem_pkg::mem_data_t exp_data [mem_pkg::NUM_MEM_TAGS+1];  // per tag, set at grant
	logic               load_open [mem_pkg::NUM_MEM_TAGS+1]; // waiting for return
	int                 grant_cycle [mem_pkg::NUM_MEM_TAGS+1];
	int                 free_cycle [mem_pkg::NUM_MEM_TAGS+1]; // first cycle tag reusable

	int          cycle;        // posedges since start
	int          fill;
	int          next_idx;
	int          pend_idx;
	logic        pending;      // command issued, no answer yet
	logic        presented;    // proc_req carries a command this cycle
	int          loads_granted;
	int          loads_returned;
	logic [31:0] lcg_state;

	mem_system dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.proc_req       (proc_req),
		.proc_busy      (proc_busy),
		.proc_grant_tag (proc_grant_tag),
		.proc_rsp       (proc_rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// cycle count, also the run limit
	initial
	begin
		cycle = 0;
		while (cycle < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle++;
		end
		$display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$fatal(1, "run did not finish in time");
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// lowest tag with no open load and its countdown over, 0 if none
	function automatic int lowest_free_tag();
		for (int i = 1; i <= mem_pkg::NUM_MEM_TAGS; i++)
		begin
			if (!load_open[i] && cycle >= free_cycle[i])
				return i;
		end
		return 0;
	endfunction

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
	                           input string what);
		if (got !== exp)
		begin
			$display("ERR %0t: %s: got %h, expected %h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "check failed");
		end
	endtask

	task automatic add_entry(input mem_pkg::bus_cmd_t op, input mem_pkg::mem_addr_t addr,
	                         input mem_pkg::mem_data_t data, input logic exp_fault);
		if (fill < NUM_STIM)
		begin
			stim[fill].op        = op;
			stim[fill].addr      = addr;
			stim[fill].data      = data;
			stim[fill].exp_fault = exp_fault;
		end
		fill++;
	endtask

	task automatic build_table();
		logic [31:0] hi;
		logic [31:0] lo;
		fill = 0;
		// store then load of the same word
		add_entry(mem_pkg::BUS_STORE, 64'h0, 64'h0123_4567_89ab_cdef, 1'b0);
		add_entry(mem_pkg::BUS_LOAD,  64'h0, '0, 1'b0);
		add_entry(mem_pkg::BUS_STORE, 64'h8, 64'hfedc_ba98_7654_3210, 1'b0);
		add_entry(mem_pkg::BUS_LOAD,  64'h8, '0, 1'b0);
		// first load sees the value before the store
		add_entry(mem_pkg::BUS_LOAD,  64'h0, '0, 1'b0);
		add_entry(mem_pkg::BUS_STORE, 64'h0, 64'h5a5a_a5a5_0f0f_f0f0, 1'b0);
		add_entry(mem_pkg::BUS_LOAD,  64'h0, '0, 1'b0);
		for (int i = 0; i < 20; i++)
		begin
			hi = lcg_next();
			lo = lcg_next();
			add_entry(mem_pkg::BUS_STORE, 64'h100 + 64'(8 * i), {hi, lo}, 1'b0);
		end
		for (int i = 0; i < 20; i++)   // load burst, more than the tag count
			add_entry(mem_pkg::BUS_LOAD, 64'h100 + 64'(8 * i), '0, 1'b0);
		add_entry(mem_pkg::BUS_STORE, 64'h103, 64'h1111_1111_1111_1111, 1'b1); // misaligned
		add_entry(mem_pkg::BUS_LOAD,  64'h100, '0, 1'b0);                      // old value
		add_entry(mem_pkg::BUS_STORE, 64'h2010, 64'h2222_2222_2222_2222, 1'b1); // past end
		add_entry(mem_pkg::BUS_LOAD,  64'h10, '0, 1'b0);                       // would alias here
		add_entry(mem_pkg::BUS_LOAD, mem_pkg::MEM_SIZE_IN_BYTES, '0, 1'b1);
		add_entry(mem_pkg::BUS_LOAD, 64'hffff_ffff_ffff_fff8, '0, 1'b1);
		add_entry(mem_pkg::BUS_LOAD, 64'h0c, '0, 1'b1);
		add_entry(mem_pkg::BUS_LOAD, 64'h1ff8, '0, 1'b0);   // never written
		add_entry(mem_pkg::BUS_LOAD, 64'h800, '0, 1'b0);
		check_equal(fill, NUM_STIM, "stimulus table length");
	endtask

	//////////////////////////////////////////////////////////////////////
	// per-cycle monitor and driver, both on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic monitor_outputs();
		int    t;
		int    line;
		int    exp_tag;
		stim_t e;
		// return bus first, a freed tag may be granted again later
		if (proc_rsp.tag != '0)
		begin
			t = int'(proc_rsp.tag);
			check_equal(load_open[t], 1'b1, $sformatf("return of tag %0d with no load", t));
			check_equal(proc_rsp.data, exp_data[t], $sformatf("load data of tag %0d", t));
			check_equal(cycle - grant_cycle[t] >= LAT + 1, 1'b1, "load returned too early");
			load_open[t]  = 1'b0;
			free_cycle[t] = cycle + 1;   // wait flag clears on this edge
			loads_returned++;
		end
		if ((proc_rsp.response != '0) || proc_rsp.fault)
		begin
			check_equal(pending, 1'b1, "answer with no command issued");
			e = stim[pend_idx];
			check_equal(proc_rsp.fault, e.exp_fault, $sformatf("fault of entry %0d", pend_idx));
			// lowest idle tag, none on a refused address
			exp_tag = e.exp_fault ? 0 : lowest_free_tag();
			check_equal(proc_rsp.response, exp_tag, $sformatf("tag of entry %0d", pend_idx));
			check_equal(proc_grant_tag, exp_tag, "grant tag to processor");
			if (!e.exp_fault)
			begin
				t    = int'(proc_rsp.response);
				line = int'(e.addr >> 3);
				if (e.op == mem_pkg::BUS_LOAD)
				begin
					exp_data[t]    = shadow[line];   // value at issue time
					load_open[t]   = 1'b1;
					grant_cycle[t] = cycle;
					loads_granted++;
				end
				else
				begin
					shadow[line]  = e.data;
					free_cycle[t] = cycle + LAT + 1;
				end
			end
			pending = 1'b0;
		end
		else if (pending)
			check_equal(proc_busy, 1'b1, "busy low while command waits");
	endtask

	task automatic drive_inputs();
		if (presented)
		begin
			proc_req  = '0;   // one cycle only
			presented = 1'b0;
		end
		if (!pending && !proc_busy && next_idx < NUM_STIM)
		begin
			proc_req.cmd  = stim[next_idx].op;
			proc_req.addr = stim[next_idx].addr;
			proc_req.data = stim[next_idx].data;
			pend_idx      = next_idx;
			next_idx++;
			pending   = 1'b1;
			presented = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int exp_loads;
		rst_n    = 1'b0;
		proc_req = '0;
		lcg_state = 32'hc094;
		next_idx  = 0;
		pend_idx  = 0;
		pending   = 1'b0;
		presented = 1'b0;
		loads_granted  = 0;
		loads_returned = 0;
		exp_loads      = 0;
		for (int i = 0; i < mem_pkg::MEM_64BIT_LINES; i++)
			shadow[i] = '0;
		for (int i = 0; i <= mem_pkg::NUM_MEM_TAGS; i++)
		begin
			load_open[i]   = 1'b0;
			free_cycle[i]  = 0;
			grant_cycle[i] = 0;
			exp_data[i]    = '0;
		end
		build_table();
		for (int i = 0; i < NUM_STIM; i++)
			if (stim[i].op == mem_pkg::BUS_LOAD && !stim[i].exp_fault)
				exp_loads++;

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// reset values
		check_equal(proc_busy, 1'b0, "busy after reset");
		check_equal(proc_rsp.response, '0, "response after reset");
		check_equal(proc_rsp.fault, 1'b0, "fault after reset");
		check_equal(proc_rsp.tag, '0, "tag after reset");
		check_equal(proc_rsp.data, '0, "data after reset");

		while (next_idx < NUM_STIM || pending || loads_returned < loads_granted)
		begin
			@(negedge clk);
			monitor_outputs();
			drive_inputs();
		end
		// quiet tail, catches a late or repeated return
		repeat (2 * LAT)
		begin
			@(negedge clk);
			monitor_outputs();
		end
		check_equal(loads_granted, exp_loads, "granted load count");
		check_equal(loads_returned, exp_loads, "returned load count");

		if (dut.u_checker.fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- bench/mem_system_checker.sv
//////////////////////////////////////////////////////////////////////
// mem_system_checker
// bound protocol assertions on tags, faults and the busy level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_system_checker (
	input logic              clk,
	input logic              rst_n,
	input mem_pkg::mem_req_t proc_req,
	input logic              proc_busy,
	input mem_pkg::mem_rsp_t proc_rsp
);

	int fail_count = 0;   // failed assertions so far

	// a command is either granted or refused, never both
	grant_xor_fault: assert property (@(posedge clk) disable iff (!rst_n)
		!((proc_rsp.response != '0) && proc_rsp.fault))
		else
		begin
			fail_count++;
			$error("response and fault set together");
		end

	// busy only comes up after a command was taken
	busy_needs_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(proc_busy) |-> $past(proc_req.cmd != mem_pkg::BUS_NONE))
		else
		begin
			fail_count++;
			$error("busy rose without a captured command");
		end

	// a load goes out on the return bus once
	tag_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(proc_rsp.tag != '0) |=> (proc_rsp.tag != $past(proc_rsp.tag)))
		else
		begin
			fail_count++;
			$error("same return tag in two consecutive cycles");
		end

	// reset leaves all outputs quiet
	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> ((proc_rsp == '0) && !proc_busy))
		else
		begin
			fail_count++;
			$error("outputs not zero after reset");
		end

endmodule

bind mem_system mem_system_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.proc_req  (proc_req),
	.proc_busy (proc_busy),
	.proc_rsp  (proc_rsp)
);

//--- verilog/mem_system.sv
//////////////////////////////////////////////////////////////////////
// mem_system
// issue buffer in front of the tagged data memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_system (
	input  logic              clk,
	input  logic              rst_n,
	input  mem_pkg::mem_req_t proc_req,
	output logic              proc_busy,
	output mem_pkg::mem_tag_t proc_grant_tag,
	output mem_pkg::mem_rsp_t proc_rsp
);

	mem_pkg::mem_req_t mem_req;   // buffer -> memory

	// memory answer goes both to the processor and back to the buffer
	mem_issue_buffer u_issue_buffer (
		.clk       (clk),
		.rst_n     (rst_n),
		.proc_req  (proc_req),
		.mem_rsp   (proc_rsp),
		.mem_req   (mem_req),
		.busy      (proc_busy),
		.grant_tag (proc_grant_tag)
	);

	mem u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (mem_req),
		.rsp   (proc_rsp)
	);

endmodule

//--- verilog/mem_issue_buffer.sv
//////////////////////////////////////////////////////////////////////
// mem_issue_buffer
// one-entry hold stage in front of the memory; keeps offering the
// command until a tag is granted or the address is refused
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_issue_buffer (
	input  logic              clk,
	input  logic              rst_n,
	input  mem_pkg::mem_req_t proc_req,
	input  mem_pkg::mem_rsp_t mem_rsp,
	output mem_pkg::mem_req_t mem_req,
	output logic              busy,       // high while a command waits
	output mem_pkg::mem_tag_t grant_tag   // copy of the memory response
);

	logic              full;      // entry holds a command
	logic              done;      // memory answered the held command
	logic              capture;   // take a new command this edge
	mem_pkg::mem_req_t held;

	// response or fault always belongs to the held command,
	// the slot offers nothing in the cycle before it fills
	assign done = (mem_rsp.response != '0) || mem_rsp.fault;

	// free again as soon as the answer shows
	assign busy = full && !done;

	assign capture = !busy && (proc_req.cmd != mem_pkg::BUS_NONE);

	assign grant_tag = mem_rsp.response;

	//////////////////////////////////////////////////////////////////////
	// full flag and holding register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			full <= 1'b0;
		else if (capture)
			full <= 1'b1;   // refill in the same edge that frees it
		else if (done)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			held <= proc_req;
	end

	//////////////////////////////////////////////////////////////////////
	// command to the memory
	//////////////////////////////////////////////////////////////////////

	// the memory sampled the command on the last edge already,
	// offering it again in the answer cycle would take a second tag
	always_comb
	begin
		mem_req = held;
		if (!busy)
		begin
			mem_req.cmd  = mem_pkg::BUS_NONE;
			mem_req.addr = '0;
			mem_req.data = '0;
		end
	end

endmodule

//--- verilog/mem.sv
//////////////////////////////////////////////////////////////////////
// mem
// tagged pipelined data memory; checks addresses, grants tags and
// returns load data with its tag after a fixed latency
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem (
	input  logic              clk,
	input  logic              rst_n,
	input  mem_pkg::mem_req_t req,
	output mem_pkg::mem_rsp_t rsp   // all fields registered
);

	logic is_load;
	logic is_cmd;
	logic valid_address;
	logic alloc;
	logic refuse;
	logic granted;

	mem_pkg::mem_tag_t  grant_tag;
	mem_pkg::mem_tag_t  ret_tag;
	mem_pkg::mem_data_t ret_data;
	mem_pkg::mem_line_t line;

	//////////////////////////////////////////////////////////////////////
	// command decode and address check
	//////////////////////////////////////////////////////////////////////

	assign is_load = (req.cmd == mem_pkg::BUS_LOAD);
	assign is_cmd  = is_load || (req.cmd == mem_pkg::BUS_STORE);

	// word aligned and inside the array
	assign valid_address = (req.addr[2:0] == 3'b0) &&
	                       (req.addr < mem_pkg::MEM_SIZE_IN_BYTES);

	assign alloc   = is_cmd && valid_address;
	assign refuse  = is_cmd && !valid_address;  // fault, never retried
	assign granted = (grant_tag != '0);         // 0 = all tags busy
	assign line    = req.addr[12:3];            // bits above 12 are zero here

	//////////////////////////////////////////////////////////////////////
	// tag bookkeeping and storage
	//////////////////////////////////////////////////////////////////////

	mem_tag_table u_tag_table (
		.clk           (clk),
		.rst_n         (rst_n),
		.alloc         (alloc),
		.alloc_is_load (is_load),
		.grant_tag     (grant_tag),
		.ret_tag       (ret_tag)
	);

	mem_store u_store (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (granted && !is_load),
		.rd_en    (granted && is_load),
		.line     (line),
		.wr_data  (req.data),
		.rd_tag   (grant_tag),
		.ret_tag  (ret_tag),
		.ret_data (ret_data)
	);

	//////////////////////////////////////////////////////////////////////
	// response register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rsp <= '0;
		else
		begin
			rsp.response <= grant_tag;  // visible the cycle after the command
			rsp.fault    <= refuse;
			rsp.tag      <= ret_tag;    // lowest ready load
			rsp.data     <= ret_data;   // zero when no tag returns
		end
	end

endmodule

//--- verilog/mem_store.sv
//////////////////////////////////////////////////////////////////////
// mem_store
// word storage with one write port, plus a load-data slot per tag
// that holds the word read at grant time until it is returned
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_store (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr_en,     // granted store
	input  logic               rd_en,     // granted load
	input  mem_pkg::mem_line_t line,      // word index, shared by both ports
	input  mem_pkg::mem_data_t wr_data,
	input  mem_pkg::mem_tag_t  rd_tag,    // slot to capture into
	input  mem_pkg::mem_tag_t  ret_tag,   // slot shown on ret_data
	output mem_pkg::mem_data_t ret_data
);

	mem_pkg::mem_data_t unified_memory [mem_pkg::MEM_64BIT_LINES];
	mem_pkg::mem_data_t loaded_data    [1:mem_pkg::NUM_MEM_TAGS];

	// main array, comes up all zero
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < mem_pkg::MEM_64BIT_LINES; i++)
				unified_memory[i] <= '0;
		end
		else if (wr_en)
			unified_memory[line] <= wr_data;
	end

	// load value is taken at grant, later stores to the word don't touch it
	always_ff @(posedge clk)
	begin
		if (rd_en)
			loaded_data[rd_tag] <= unified_memory[line];
	end

	// tag 0 has no slot
	assign ret_data = (ret_tag == '0) ? '0 : loaded_data[ret_tag];

endmodule

//--- verilog/mem_tag_table.sv
//////////////////////////////////////////////////////////////////////
// mem_tag_table
// per-tag latency counters and bus-wait flags; hands out the lowest
// free tag and picks the lowest finished load for the return bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_tag_table (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              alloc,          // valid command wants a tag
	input  logic              alloc_is_load,  // load keeps its tag until sent
	output mem_pkg::mem_tag_t grant_tag,      // 0 = nothing free
	output mem_pkg::mem_tag_t ret_tag         // 0 = no load ready
);

	// one slot per tag, tag 0 has no slot
	mem_pkg::lat_cnt_t [mem_pkg::NUM_MEM_TAGS:1] cycles_left;
	logic [mem_pkg::NUM_MEM_TAGS:1]              waiting_for_bus;

	logic [mem_pkg::NUM_MEM_TAGS:1] tag_free;   // idle, can be granted
	logic [mem_pkg::NUM_MEM_TAGS:1] tag_ready;  // load done counting

	//////////////////////////////////////////////////////////////////////
	// per-tag status
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 1; i <= mem_pkg::NUM_MEM_TAGS; i++)
		begin
			tag_free[i]  = (cycles_left[i] == '0) && !waiting_for_bus[i];
			tag_ready[i] = (cycles_left[i] == '0) && waiting_for_bus[i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// priority picks
	//////////////////////////////////////////////////////////////////////

	// walk downwards so the lowest qualifying tag is written last
	always_comb
	begin
		grant_tag = '0;
		if (alloc)
		begin
			for (int i = mem_pkg::NUM_MEM_TAGS; i >= 1; i--)
			begin
				if (tag_free[i])
					grant_tag = mem_pkg::mem_tag_t'(i);
			end
		end
	end

	// one load per cycle on the return bus, lowest tag first
	always_comb
	begin
		ret_tag = '0;
		for (int i = mem_pkg::NUM_MEM_TAGS; i >= 1; i--)
		begin
			if (tag_ready[i])
				ret_tag = mem_pkg::mem_tag_t'(i);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// counters and wait flags
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cycles_left     <= '0;
			waiting_for_bus <= '0;
		end
		else
		begin
			for (int i = 1; i <= mem_pkg::NUM_MEM_TAGS; i++)
			begin
				if (grant_tag == mem_pkg::mem_tag_t'(i))
				begin
					// fresh grant, start the countdown
					cycles_left[i]     <= mem_pkg::MEM_LATENCY_IN_CYCLES;
					waiting_for_bus[i] <= alloc_is_load;  // stores free at zero
				end
				else
				begin
					if (cycles_left[i] != '0)
						cycles_left[i] <= cycles_left[i] - mem_pkg::lat_cnt_t'(1);
					if (ret_tag == mem_pkg::mem_tag_t'(i))
						waiting_for_bus[i] <= 1'b0;  // data leaves this edge
				end
			end
		end
	end

	// a ready tag is never free, so grant and return never hit one slot

endmodule

//--- verilog/mem_pkg.sv
//////////////////////////////////////////////////////////////////////
// mem_pkg
// sizes, vector types and bus structs shared by the tagged
// pipelined data memory and its issue buffer
//////////////////////////////////////////////////////////////////////

package mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [63:0] mem_addr_t;   // byte address
	typedef logic [63:0] mem_data_t;   // one 64-bit word
	typedef logic [3:0]  mem_tag_t;    // 0 = none / refused
	typedef logic [9:0]  mem_line_t;   // word index into storage
	typedef logic [15:0] lat_cnt_t;    // per-tag countdown

	//////////////////////////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned NUM_MEM_TAGS          = 15;
	localparam lat_cnt_t    MEM_LATENCY_IN_CYCLES = 16'd6;
	localparam int unsigned MEM_64BIT_LINES       = 1024;
	localparam mem_addr_t   MEM_SIZE_IN_BYTES     = 64'(8 * MEM_64BIT_LINES);

	// bus command, same codes as the old BUS_* defines
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_t;

	// processor -> memory command
	typedef struct packed {
		bus_cmd_t  cmd;
		mem_addr_t addr;
		mem_data_t data;   // store data, ignored on loads
	} mem_req_t;

	// memory -> processor
	typedef struct packed {
		mem_tag_t  response;   // tag granted this cycle, 0 = not accepted
		logic      fault;      // one-cycle pulse, address refused
		mem_tag_t  tag;        // tag of returning load, 0 = none
		mem_data_t data;       // load data that goes with tag
	} mem_rsp_t;

endpackage
